//--- logic/pkt_cfg.svh
`ifndef PKT_CFG_SVH
`define PKT_CFG_SVH

// ********************************************************************
// Receive endpoint build settings
// ********************************************************************

// Byte lanes per phit.
`define PHIT_LANES 8

// Bits per lane.
`define LANE_BITS 8

// Lanes taken by the header; must stay 16 bits wide.
`define HDR_LANES 2

// Phits held in the input buffer.
`define FIFO_DEPTH 8

`endif

//--- logic/pkt_pkg.sv
`default_nettype none
`include "pkt_cfg.svh"

package pkt_pkg;

    localparam int HDR_BITS  = `HDR_LANES * `LANE_BITS;
    localparam int NODE_BITS = 7;
    localparam int REG_BITS  = 16;

    typedef logic [`PHIT_LANES*`LANE_BITS-1:0] phit_t;
    typedef logic [`PHIT_LANES-1:0]            lanes_t;

    // ********************************************************************
    // Header views, both 16 bits with the kind bit on top
    // ********************************************************************
    typedef struct packed {
        logic                 kind;
        logic [NODE_BITS-1:0] dest;
        logic [7:0]           tag;
    } hdr_route_t;

    typedef struct packed {
        logic        kind;
        logic [2:0]  op;
        logic [11:0] arg;
    } hdr_ctrl_t;

    typedef union packed {
        hdr_route_t route;
        hdr_ctrl_t  ctrl;
    } pkt_hdr_u;

    typedef enum logic [1:0] {
        REG_NODE_ID   = 2'd0,
        REG_MATCH_CNT = 2'd1,
        REG_MISS_CNT  = 2'd2,
        REG_CTRL_CNT  = 2'd3
    } reg_addr_e;

endpackage

`default_nettype wire

//--- logic/pkt_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "pkt_cfg.svh"

module pkt_fifo import pkt_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   in_valid,
    input  phit_t  in_data,
    input  lanes_t in_lanes,
    input  logic   in_last,
    input  logic   fifo_pop,
    output logic   in_ready,
    output logic   fifo_empty,
    output phit_t  head_data,
    output lanes_t head_lanes,
    output logic   head_last
);

    localparam int PTR_W = (`FIFO_DEPTH > 1) ? $clog2(`FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

    phit_t            mem_data  [`FIFO_DEPTH];
    lanes_t           mem_lanes [`FIFO_DEPTH];
    logic             mem_last  [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;

    // Wraps at the depth, which need not be a power of two.
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in_ready   = (count != CNT_W'(`FIFO_DEPTH));
    assign fifo_empty = (count == '0);
    assign push       = in_valid && in_ready;

    assign head_data  = mem_data[rd_ptr];
    assign head_lanes = mem_lanes[rd_ptr];
    assign head_last  = mem_last[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (fifo_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, fifo_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wr_ptr]  <= in_data;
            mem_lanes[wr_ptr] <= in_lanes;
            mem_last[wr_ptr]  <= in_last;
        end
    end

    // The stripper must never pop an empty buffer.
    a_pop_nonempty: assert property (@(posedge clk) disable iff (rst)
        fifo_pop |-> !fifo_empty);

    // Pointers meet only when the buffer is empty or full.
    a_ptr_count: assert property (@(posedge clk) disable iff (rst)
        (wr_ptr == rd_ptr) == ((count == '0) || (count == CNT_W'(`FIFO_DEPTH))));

endmodule

`default_nettype wire

//--- logic/hdr_strip.sv
`timescale 1ns/1ps
`default_nettype none
`include "pkt_cfg.svh"

module hdr_strip import pkt_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                fifo_empty,
    input  phit_t               head_data,
    input  lanes_t              head_lanes,
    input  logic                head_last,
    input  logic                out_ready,
    output logic                fifo_pop,
    output logic                is_header,
    output logic [HDR_BITS-1:0] hdr_word,
    output logic                out_valid,
    output phit_t               out_data,
    output lanes_t              out_lanes,
    output logic                out_last
);

    localparam int UP_LANES = `PHIT_LANES - `HDR_LANES;
    localparam int UP_BITS  = UP_LANES * `LANE_BITS;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PAYLOAD,
        ST_FLUSH
    } strip_state_e;

    strip_state_e        state;
    strip_state_e        state_nxt;

    // Upper lanes of the previous phit, already moved down to lane 0.
    logic [UP_BITS-1:0]  held_data;
    logic [UP_LANES-1:0] held_lanes;

    logic [UP_LANES-1:0] head_up_lanes;
    logic                stall;
    logic                emit;
    logic                emit_last;
    phit_t               nxt_data;
    lanes_t              nxt_lanes;

    assign head_up_lanes = head_lanes[`PHIT_LANES-1:`HDR_LANES];
    assign stall         = out_valid && !out_ready;
    assign fifo_pop      = !fifo_empty && !stall && (state != ST_FLUSH);
    assign is_header     = fifo_pop && (state == ST_IDLE);
    assign hdr_word      = head_data[HDR_BITS-1:0];

    // ********************************************************************
    // Next state and next output phit
    // ********************************************************************
    always_comb begin
        state_nxt = state;
        emit      = 1'b0;
        emit_last = 1'b0;
        nxt_data  = {head_data[HDR_BITS-1:0], held_data};
        nxt_lanes = {head_lanes[`HDR_LANES-1:0], held_lanes};
        case (state)
            ST_IDLE: begin
                if (fifo_pop) begin
                    if (!head_last) begin
                        state_nxt = ST_HEADER;
                    end else if (|head_up_lanes) begin
                        state_nxt = ST_FLUSH;
                    end
                end
            end
            ST_HEADER, ST_PAYLOAD: begin
                if (fifo_pop) begin
                    emit = 1'b1;
                    if (!head_last) begin
                        state_nxt = ST_PAYLOAD;
                    end else if (|head_up_lanes) begin
                        state_nxt = ST_FLUSH;
                    end else begin
                        emit_last = 1'b1;
                        state_nxt = ST_IDLE;
                    end
                end
            end
            ST_FLUSH: begin
                // Leftover upper lanes go out alone.
                emit      = 1'b1;
                emit_last = 1'b1;
                nxt_data  = {{HDR_BITS{1'b0}}, held_data};
                nxt_lanes = {{`HDR_LANES{1'b0}}, held_lanes};
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (!stall) begin
            state     <= state_nxt;
            out_valid <= emit;
            out_last  <= emit_last;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            held_data  <= head_data[`PHIT_LANES*`LANE_BITS-1:HDR_BITS];
            held_lanes <= head_up_lanes;
        end
        if (emit && !stall) begin
            out_data  <= nxt_data;
            out_lanes <= nxt_lanes;
        end
    end

    // Output lanes fill from lane 0 with no holes.
    a_lanes_contig: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> (out_lanes != '0) && ((out_lanes & lanes_t'(out_lanes + 1'b1)) == '0));

endmodule

`default_nettype wire

//--- logic/hdr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module hdr_decode import pkt_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 is_header,
    input  logic [HDR_BITS-1:0]  hdr_word,
    input  logic [NODE_BITS-1:0] node_id,
    output logic                 route_hit,
    output logic                 route_miss,
    output logic                 ctrl_seen,
    output logic                 route_tag_valid,
    output logic [7:0]           route_tag,
    output logic                 ctrl_valid,
    output logic [2:0]           ctrl_op,
    output logic [11:0]          ctrl_arg
);

    pkt_hdr_u   hdr_q;
    logic       hdr_pend;
    logic       is_ctrl;
    logic [2:0] events;

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_pend <= 1'b0;
        end else begin
            hdr_pend <= is_header;
        end
    end

    always_ff @(posedge clk) begin
        if (is_header) begin
            hdr_q <= pkt_hdr_u'(hdr_word);
        end
    end

    // Kind bit is the top bit in both views.
    assign is_ctrl = hdr_q.ctrl.kind;

    assign ctrl_valid      = hdr_pend && is_ctrl;
    assign ctrl_op         = hdr_q.ctrl.op;
    assign ctrl_arg        = hdr_q.ctrl.arg;
    assign route_tag_valid = hdr_pend && !is_ctrl;
    assign route_tag       = hdr_q.route.tag;

    assign route_hit  = route_tag_valid && (hdr_q.route.dest == node_id);
    assign route_miss = route_tag_valid && (hdr_q.route.dest != node_id);
    assign ctrl_seen  = ctrl_valid;

    assign events = {ctrl_seen, route_miss, route_hit};

    // Exactly one event follows each header by one cycle.
    a_one_event: assert property (@(posedge clk) disable iff (rst)
        is_header |=> $onehot(events));

endmodule

`default_nettype wire

//--- logic/rx_regs.sv
`timescale 1ns/1ps
`default_nettype none

module rx_regs import pkt_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 reg_wr,
    input  reg_addr_e            reg_addr,
    input  logic [REG_BITS-1:0]  reg_wdata,
    input  logic                 route_hit,
    input  logic                 route_miss,
    input  logic                 ctrl_seen,
    output logic [REG_BITS-1:0]  reg_rdata,
    output logic [NODE_BITS-1:0] node_id
);

    localparam int NUM_EVT = 3;

    logic [NUM_EVT-1:0]  evt;
    logic [REG_BITS-1:0] evt_cnt [NUM_EVT];

    // Order matches the counter addresses.
    assign evt = {ctrl_seen, route_miss, route_hit};

    // ********************************************************************
    // Node address, the only writable register
    // ********************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            node_id <= '0;
        end else if (reg_wr && (reg_addr == REG_NODE_ID)) begin
            node_id <= reg_wdata[NODE_BITS-1:0];
        end
    end

    // ********************************************************************
    // Event counters, wrapping
    // ********************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_EVT; i++) begin
                evt_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_EVT; i++) begin
                if (evt[i]) begin
                    evt_cnt[i] <= evt_cnt[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (reg_addr)
            REG_NODE_ID: begin
                reg_rdata = {{(REG_BITS-NODE_BITS){1'b0}}, node_id};
            end
            REG_MATCH_CNT: begin
                reg_rdata = evt_cnt[0];
            end
            REG_MISS_CNT: begin
                reg_rdata = evt_cnt[1];
            end
            REG_CTRL_CNT: begin
                reg_rdata = evt_cnt[2];
            end
            default: begin
                reg_rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/pkt_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_rx_top import pkt_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  phit_t               in_data,
    input  lanes_t              in_lanes,
    input  logic                in_last,
    output logic                in_ready,
    output logic                out_valid,
    output phit_t               out_data,
    output lanes_t              out_lanes,
    output logic                out_last,
    input  logic                out_ready,
    input  logic                reg_wr,
    input  reg_addr_e           reg_addr,
    input  logic [REG_BITS-1:0] reg_wdata,
    output logic [REG_BITS-1:0] reg_rdata,
    output logic                ctrl_valid,
    output logic [2:0]          ctrl_op,
    output logic [11:0]         ctrl_arg,
    output logic                route_tag_valid,
    output logic [7:0]          route_tag
);

    logic                 fifo_empty;
    logic                 fifo_pop;
    phit_t                head_data;
    lanes_t               head_lanes;
    logic                 head_last;
    logic                 is_header;
    logic [HDR_BITS-1:0]  hdr_word;
    logic [NODE_BITS-1:0] node_id;
    logic                 route_hit;
    logic                 route_miss;
    logic                 ctrl_seen;

    pkt_fifo pkt_fifo_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_lanes   (in_lanes),
        .in_last    (in_last),
        .fifo_pop   (fifo_pop),
        .in_ready   (in_ready),
        .fifo_empty (fifo_empty),
        .head_data  (head_data),
        .head_lanes (head_lanes),
        .head_last  (head_last)
    );

    hdr_strip hdr_strip_i (
        .clk        (clk),
        .rst        (rst),
        .fifo_empty (fifo_empty),
        .head_data  (head_data),
        .head_lanes (head_lanes),
        .head_last  (head_last),
        .out_ready  (out_ready),
        .fifo_pop   (fifo_pop),
        .is_header  (is_header),
        .hdr_word   (hdr_word),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_lanes  (out_lanes),
        .out_last   (out_last)
    );

    hdr_decode hdr_decode_i (
        .clk             (clk),
        .rst             (rst),
        .is_header       (is_header),
        .hdr_word        (hdr_word),
        .node_id         (node_id),
        .route_hit       (route_hit),
        .route_miss      (route_miss),
        .ctrl_seen       (ctrl_seen),
        .route_tag_valid (route_tag_valid),
        .route_tag       (route_tag),
        .ctrl_valid      (ctrl_valid),
        .ctrl_op         (ctrl_op),
        .ctrl_arg        (ctrl_arg)
    );

    rx_regs rx_regs_i (
        .clk        (clk),
        .rst        (rst),
        .reg_wr     (reg_wr),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .route_hit  (route_hit),
        .route_miss (route_miss),
        .ctrl_seen  (ctrl_seen),
        .reg_rdata  (reg_rdata),
        .node_id    (node_id)
    );

endmodule

`default_nettype wire

//--- tb/tb_pkt_rx.sv
`timescale 1ns/1ps
`default_nettype none
`include "pkt_cfg.svh"

module tb_pkt_rx import pkt_pkg::*; ();

    localparam int NUM_PKTS     = 80;
    localparam int MAX_BYTES    = 48;
    localparam int ACCEPT_LIMIT = 500;
    localparam int DRAIN_LIMIT  = 3000;

    logic                 clk;
    logic                 rst;
    logic                 in_valid;
    phit_t                in_data;
    lanes_t               in_lanes;
    logic                 in_last;
    logic                 in_ready;
    logic                 out_valid;
    phit_t                out_data;
    lanes_t               out_lanes;
    logic                 out_last;
    logic                 out_ready;
    logic                 reg_wr;
    reg_addr_e            reg_addr;
    logic [REG_BITS-1:0]  reg_wdata;
    logic [REG_BITS-1:0]  reg_rdata;
    logic                 ctrl_valid;
    logic [2:0]           ctrl_op;
    logic [11:0]          ctrl_arg;
    logic                 route_tag_valid;
    logic [7:0]           route_tag;

    // Reference model state.
    logic [31:0]          lfsr_state;
    int                   stall_left;
    logic [NODE_BITS-1:0] node_id_model;
    int                   hit_cnt;
    int                   miss_cnt;
    int                   ctrl_cnt;
    int                   pkt_left;
    logic [7:0]           exp_bytes [$];
    int                   exp_len [$];
    pkt_hdr_u             exp_hdr [$];

    pkt_rx_top pkt_rx_top_i (
        .clk             (clk),
        .rst             (rst),
        .in_valid        (in_valid),
        .in_data         (in_data),
        .in_lanes        (in_lanes),
        .in_last         (in_last),
        .in_ready        (in_ready),
        .out_valid       (out_valid),
        .out_data        (out_data),
        .out_lanes       (out_lanes),
        .out_last        (out_last),
        .out_ready       (out_ready),
        .reg_wr          (reg_wr),
        .reg_addr        (reg_addr),
        .reg_wdata       (reg_wdata),
        .reg_rdata       (reg_rdata),
        .ctrl_valid      (ctrl_valid),
        .ctrl_op         (ctrl_op),
        .ctrl_arg        (ctrl_arg),
        .route_tag_valid (route_tag_valid),
        .route_tag       (route_tag)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ********************************************************************
    // Random source and failure path
    // ********************************************************************

    // Galois LFSR stepped once per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hD000_0001) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic phit_t lane_mask(input lanes_t l);
        phit_t m;
        m = '0;
        for (int i = 0; i < `PHIT_LANES; i++) begin
            if (l[i]) begin
                m[i*`LANE_BITS +: `LANE_BITS] = '1;
            end
        end
        return m;
    endfunction

    // ********************************************************************
    // Compare tasks
    // ********************************************************************
    task automatic check_phit(input phit_t got_d, input lanes_t got_l,
                              input phit_t exp_d, input lanes_t exp_l);
        if (got_l !== exp_l) begin
            fail_now($sformatf("CHECK FAILED at %0t: out_lanes got %b expected %b",
                               $time, got_l, exp_l));
        end
        if (got_d !== exp_d) begin
            fail_now($sformatf("CHECK FAILED at %0t: out_data got %h expected %h",
                               $time, got_d, exp_d));
        end
    endtask

    task automatic check_last(input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED at %0t: out_last got %b expected %b",
                               $time, got, exp));
        end
    endtask

    task automatic check_hdr(input pkt_hdr_u got, input pkt_hdr_u exp);
        if (got.ctrl.kind !== exp.ctrl.kind) begin
            fail_now($sformatf("CHECK FAILED at %0t: header kind got %b expected %b",
                               $time, got.ctrl.kind, exp.ctrl.kind));
        end
        if (exp.ctrl.kind && (got.ctrl !== exp.ctrl)) begin
            fail_now($sformatf("CHECK FAILED at %0t: ctrl_op/ctrl_arg got %h/%h expected %h/%h",
                               $time, got.ctrl.op, got.ctrl.arg, exp.ctrl.op, exp.ctrl.arg));
        end
        if (!exp.ctrl.kind && (got.route.tag !== exp.route.tag)) begin
            fail_now($sformatf("CHECK FAILED at %0t: route_tag got %h expected %h",
                               $time, got.route.tag, exp.route.tag));
        end
    endtask

    task automatic check_reg(input string name, input logic [REG_BITS-1:0] got,
                             input logic [REG_BITS-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    // ********************************************************************
    // Stimulus
    // ********************************************************************

    // Steps to the falling edge and draws a new out_ready level or a long stall.
    task automatic tick();
        logic [3:0] r;
        @(negedge clk);
        if (stall_left > 0) begin
            out_ready  = 1'b0;
            stall_left = stall_left - 1;
        end else begin
            r = 4'(rand_bits(4));
            if (r == 4'd0) begin
                stall_left = 12;
                out_ready  = 1'b0;
            end else begin
                out_ready = (r >= 4'd4);
            end
        end
    endtask

    task automatic send_phit(input phit_t d, input lanes_t l, input logic last);
        int   waited;
        logic took;
        if (rand_bits(2) == 0) begin
            repeat (rand_bits(2) + 1) tick();
        end
        in_valid = 1'b1;
        in_data  = d;
        in_lanes = l;
        in_last  = last;
        waited   = 0;
        took     = 1'b0;
        while (!took) begin
            @(posedge clk);
            took = in_ready;
            tick();
            waited = waited + 1;
            if (!took && (waited > ACCEPT_LIMIT)) begin
                fail_now("Timeout: the input buffer never accepted a phit.");
            end
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic send_packet();
        pkt_hdr_u             hdr;
        logic [NODE_BITS-1:0] dest;
        logic [7:0]           pkt_bytes [MAX_BYTES];
        int                   len;
        int                   total;
        int                   nphits;
        int                   idx;
        phit_t                d;
        lanes_t               l;
        hdr = '0;
        if (rand_bits(1) != 0) begin
            hdr.ctrl.kind = 1'b1;
            hdr.ctrl.op   = 3'(rand_bits(3));
            hdr.ctrl.arg  = 12'(rand_bits(12));
            ctrl_cnt      = ctrl_cnt + 1;
        end else begin
            // Some routing headers aim at this node on purpose.
            if (rand_bits(2) == 0) begin
                dest = node_id_model;
            end else begin
                dest = NODE_BITS'(rand_bits(NODE_BITS));
            end
            hdr.route.kind = 1'b0;
            hdr.route.dest = dest;
            hdr.route.tag  = 8'(rand_bits(8));
            if (dest == node_id_model) begin
                hit_cnt = hit_cnt + 1;
            end else begin
                miss_cnt = miss_cnt + 1;
            end
        end
        exp_hdr.push_back(hdr);
        len   = rand_bits(6) % 41;
        total = len + `HDR_LANES;
        for (int i = 0; i < `HDR_LANES; i++) begin
            pkt_bytes[i] = hdr[i*`LANE_BITS +: `LANE_BITS];
        end
        for (int i = `HDR_LANES; i < total; i++) begin
            pkt_bytes[i] = 8'(rand_bits(8));
            exp_bytes.push_back(pkt_bytes[i]);
        end
        if (len > 0) begin
            exp_len.push_back(len);
        end
        nphits = (total + `PHIT_LANES - 1) / `PHIT_LANES;
        for (int p = 0; p < nphits; p++) begin
            d = '0;
            l = '0;
            for (int k = 0; k < `PHIT_LANES; k++) begin
                idx = p * `PHIT_LANES + k;
                if (idx < total) begin
                    d[k*`LANE_BITS +: `LANE_BITS] = pkt_bytes[idx];
                    l[k] = 1'b1;
                end
            end
            send_phit(d, l, p == nphits - 1);
        end
    endtask

    task automatic read_reg(input reg_addr_e a, input int exp, input string name);
        tick();
        reg_addr = a;
        tick();
        check_reg(name, reg_rdata, REG_BITS'(exp));
    endtask

    // ********************************************************************
    // Output and header monitors
    // ********************************************************************
    initial begin : out_monitor
        int     n;
        phit_t  exp_d;
        lanes_t exp_l;
        forever begin
            @(posedge clk);
            if (!rst && out_valid && out_ready) begin
                if (pkt_left == 0) begin
                    if (exp_len.size() == 0) begin
                        fail_now("An output phit arrived with no payload pending.");
                    end
                    pkt_left = exp_len.pop_front();
                end
                n     = (pkt_left < `PHIT_LANES) ? pkt_left : `PHIT_LANES;
                exp_d = '0;
                exp_l = '0;
                for (int k = 0; k < n; k++) begin
                    exp_d[k*`LANE_BITS +: `LANE_BITS] = exp_bytes.pop_front();
                    exp_l[k] = 1'b1;
                end
                check_phit(out_data & lane_mask(out_lanes), out_lanes, exp_d, exp_l);
                pkt_left = pkt_left - n;
                check_last(out_last, pkt_left == 0);
            end
        end
    end

    initial begin : hdr_monitor
        pkt_hdr_u exp_h;
        pkt_hdr_u got_h;
        forever begin
            @(posedge clk);
            if (!rst && (ctrl_valid || route_tag_valid)) begin
                if (exp_hdr.size() == 0) begin
                    fail_now("A header decode appeared with no header pending.");
                end
                if (ctrl_valid && route_tag_valid) begin
                    fail_now("Control and route decodes were both valid in one cycle.");
                end
                exp_h = exp_hdr.pop_front();
                if (ctrl_valid) begin
                    got_h.ctrl = {1'b1, ctrl_op, ctrl_arg};
                end else begin
                    // Destination is not visible at the top level.
                    got_h.route = {1'b0, exp_h.route.dest, route_tag};
                end
                check_hdr(got_h, exp_h);
            end
        end
    end

    // ********************************************************************
    // Main sequence
    // ********************************************************************
    initial begin : main_seq
        int waited;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_data    = '0;
        in_lanes   = '0;
        in_last    = 1'b0;
        out_ready  = 1'b0;
        reg_wr     = 1'b0;
        reg_addr   = REG_NODE_ID;
        reg_wdata  = '0;
        lfsr_state = 32'd72895;
        stall_left = 0;
        hit_cnt    = 0;
        miss_cnt   = 0;
        ctrl_cnt   = 0;
        pkt_left   = 0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        if (!in_ready || out_valid || ctrl_valid || route_tag_valid) begin
            fail_now("Outputs were not at their reset levels after reset.");
        end

        node_id_model = NODE_BITS'(rand_bits(NODE_BITS));
        tick();
        reg_wr    = 1'b1;
        reg_addr  = REG_NODE_ID;
        reg_wdata = REG_BITS'(node_id_model);
        tick();
        reg_wr = 1'b0;
        read_reg(REG_NODE_ID, int'(node_id_model), "node_id");

        for (int p = 0; p < NUM_PKTS; p++) begin
            send_packet();
        end

        waited = 0;
        while ((exp_len.size() != 0) || (pkt_left != 0) || (exp_hdr.size() != 0)) begin
            tick();
            waited = waited + 1;
            if (waited > DRAIN_LIMIT) begin
                fail_now("Timeout: the expected output never arrived.");
            end
        end

        read_reg(REG_MATCH_CNT, hit_cnt, "route match count");
        read_reg(REG_MISS_CNT, miss_cnt, "route miss count");
        read_reg(REG_CTRL_CNT, ctrl_cnt, "control count");

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+logic
logic/pkt_pkg.sv
logic/pkt_fifo.sv
logic/hdr_strip.sv
logic/hdr_decode.sv
logic/rx_regs.sv
logic/pkt_rx_top.sv
tb/tb_pkt_rx.sv

//--- Bender.yml
package:
  name: pkt_rx

sources:
  - include_dirs:
      - logic
    files:
      - logic/pkt_pkg.sv
      - logic/pkt_fifo.sv
      - logic/hdr_strip.sv
      - logic/hdr_decode.sv
      - logic/rx_regs.sv
      - logic/pkt_rx_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/tb_pkt_rx.sv
